//--- include/adc_stream_cfg.svh
`ifndef ADC_STREAM_CFG_SVH
`define ADC_STREAM_CFG_SVH

// one beat packs eight words of the capture stream.
`define ADC_BEAT_WIDTH 128
`define ADC_WORD_WIDTH 16

// the ramp sample is left-aligned inside each word.
`define ADC_RES_WIDTH 12

// both depths are powers of two so that the pointers wrap on their own.
`define ADC_BEAT_FIFO_DEPTH 4
`define ADC_SAMPLE_FIFO_DEPTH 16

`endif

//--- hw/adc_stream_pkg.sv
`default_nettype none

`include "adc_stream_cfg.svh"

package adc_stream_pkg;

  // a full beat as it leaves the source.
  typedef logic [`ADC_BEAT_WIDTH-1:0] beat_t;

  // one serialized word with the sample in its upper bits.
  typedef logic [`ADC_WORD_WIDTH-1:0] word_t;

  typedef logic [`ADC_RES_WIDTH-1:0] sample_t;  // bare ramp value.

  // wrap limit, unsigned. The ramp wraps after reaching twice this value.
  typedef logic [`ADC_RES_WIDTH-1:0] limit_t;

  localparam int WORDS_PER_BEAT = `ADC_BEAT_WIDTH / `ADC_WORD_WIDTH;

endpackage

`default_nettype wire

//--- hw/adc_dummy_source.sv
`default_nettype none
`timescale 1ns/100ps

`include "adc_stream_cfg.svh"

module adc_dummy_source (
  input  logic                     CLK,
  input  logic                     ARESETN,
  input  adc_stream_pkg::limit_t   count_limit,
  input  logic                     src_ready,
  output adc_stream_pkg::beat_t    src_data,
  output logic                     src_valid
);

  localparam int PAD_WIDTH = `ADC_WORD_WIDTH - `ADC_RES_WIDTH;

  adc_stream_pkg::limit_t  limit_q;
  adc_stream_pkg::sample_t sample_q;
  adc_stream_pkg::word_t   word_val;
  logic                    valid_q;
  logic [`ADC_RES_WIDTH:0] wrap_point;
  logic                    wrap;
  logic                    accept;

  // the limit only follows the input while reset is held.
  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      limit_q <= count_limit;
    end
  end

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;  // free running once out of reset.
    end
  end

  assign accept = valid_q && src_ready;

  // twice the limit needs one bit more than the sample itself.
  assign wrap_point = {limit_q, 1'b0};
  assign wrap       = {1'b0, sample_q} >= wrap_point;

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      sample_q <= '0;
    end else if (accept) begin
      if (wrap) begin
        sample_q <= '0;
      end else begin
        sample_q <= sample_q + 1'b1;
      end
    end
  end

  // every word of a beat carries the same left-aligned sample.
  assign word_val  = {sample_q, {PAD_WIDTH{1'b0}}};
  assign src_data  = {adc_stream_pkg::WORDS_PER_BEAT{word_val}};
  assign src_valid = valid_q;

endmodule

`default_nettype wire

//--- hw/axis_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module axis_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     CLK,
  input  logic     ARESETN,
  input  payload_t s_data,
  input  logic     s_valid,
  output logic     s_ready,
  output payload_t m_data,
  output logic     m_valid,
  input  logic     m_ready
);

  // DEPTH is a power of two, so the pointers wrap without a compare.
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr_q;
  logic [AW-1:0]   rd_ptr_q;
  logic [CW-1:0]   count_q;
  logic            full;
  logic            wr_en;
  logic            rd_en;

  assign full    = (count_q == CW'(DEPTH));
  assign m_valid = (count_q != '0);

  // a read frees a slot in the same cycle, so a full FIFO still takes a write.
  assign s_ready = !full || m_ready;

  assign wr_en = s_valid && s_ready;
  assign rd_en = m_valid && m_ready;

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= s_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      count_q <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle, or both at once.
      endcase
    end
  end

  // show-ahead output: the head entry is always on the bus.
  assign m_data = mem[rd_ptr_q];

endmodule

`default_nettype wire

//--- hw/beat_serializer.sv
`default_nettype none
`timescale 1ns/100ps

`include "adc_stream_cfg.svh"

module beat_serializer (
  input  logic                    CLK,
  input  logic                    ARESETN,
  input  adc_stream_pkg::beat_t   beat_data,
  input  logic                    beat_valid,
  output logic                    beat_ready,
  output adc_stream_pkg::word_t   ser_data,
  output logic                    ser_valid,
  input  logic                    ser_ready
);

  localparam int IW = $clog2(adc_stream_pkg::WORDS_PER_BEAT);
  localparam logic [IW-1:0] LAST_IDX = IW'(adc_stream_pkg::WORDS_PER_BEAT - 1);

  adc_stream_pkg::beat_t beat_q;
  logic [IW-1:0]         idx_q;
  logic                  valid_q;
  logic                  word_xfer;
  logic                  last_word;
  logic                  take;

  assign word_xfer = valid_q && ser_ready;
  assign last_word = (idx_q == LAST_IDX);

  // a new beat enters while idle, or as the last word leaves.
  assign beat_ready = !valid_q || (word_xfer && last_word);
  assign take       = beat_valid && beat_ready;

  always_ff @(posedge CLK) begin
    if (take) begin
      beat_q <= beat_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      valid_q <= 1'b0;
      idx_q   <= '0;
    end else if (take) begin
      valid_q <= 1'b1;
      idx_q   <= '0;  // lowest word goes first.
    end else if (word_xfer) begin
      if (last_word) begin
        valid_q <= 1'b0;  // nothing waiting upstream.
      end
      idx_q <= idx_q + 1'b1;
    end
  end

  assign ser_data  = beat_q[idx_q*`ADC_WORD_WIDTH +: `ADC_WORD_WIDTH];
  assign ser_valid = valid_q;

endmodule

`default_nettype wire

//--- hw/adc_stream_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "adc_stream_cfg.svh"

module adc_stream_top (
  input  logic                    CLK,
  input  logic                    ARESETN,
  input  adc_stream_pkg::limit_t  count_limit,
  input  logic                    m_axis_tready,
  output adc_stream_pkg::word_t   m_axis_tdata,
  output logic                    m_axis_tvalid
);

  adc_stream_pkg::beat_t src_data;
  logic                  src_valid;
  logic                  src_ready;

  adc_stream_pkg::beat_t beat_data;
  logic                  beat_valid;
  logic                  beat_ready;

  adc_stream_pkg::word_t ser_data;
  logic                  ser_valid;
  logic                  ser_ready;

  adc_dummy_source src0 (
    .CLK         (CLK),
    .ARESETN     (ARESETN),
    .count_limit (count_limit),
    .src_ready   (src_ready),
    .src_data    (src_data),
    .src_valid   (src_valid)
  );

  // a few beats of slack between the ramp and the serializer.
  axis_fifo #(
    .payload_t (adc_stream_pkg::beat_t),
    .DEPTH     (`ADC_BEAT_FIFO_DEPTH)
  ) beat_fifo0 (
    .CLK     (CLK),
    .ARESETN (ARESETN),
    .s_data  (src_data),
    .s_valid (src_valid),
    .s_ready (src_ready),
    .m_data  (beat_data),
    .m_valid (beat_valid),
    .m_ready (beat_ready)
  );

  beat_serializer ser0 (
    .CLK        (CLK),
    .ARESETN    (ARESETN),
    .beat_data  (beat_data),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .ser_data   (ser_data),
    .ser_valid  (ser_valid),
    .ser_ready  (ser_ready)
  );

  axis_fifo #(
    .payload_t (adc_stream_pkg::word_t),
    .DEPTH     (`ADC_SAMPLE_FIFO_DEPTH)
  ) sample_fifo0 (
    .CLK     (CLK),
    .ARESETN (ARESETN),
    .s_data  (ser_data),
    .s_valid (ser_valid),
    .s_ready (ser_ready),
    .m_data  (m_axis_tdata),
    .m_valid (m_axis_tvalid),
    .m_ready (m_axis_tready)
  );

endmodule

`default_nettype wire

//--- testbench/adc_stream_assertions.sv
`default_nettype none
`timescale 1ns/100ps

`include "adc_stream_cfg.svh"

module adc_stream_assertions (
  input logic                  CLK,
  input logic                  ARESETN,
  input adc_stream_pkg::word_t m_axis_tdata,
  input logic                  m_axis_tvalid,
  input logic                  m_axis_tready
);

  localparam int PAD_WIDTH = `ADC_WORD_WIDTH - `ADC_RES_WIDTH;

  // the sample FIFO count is cleared on every edge that sees reset.
  property p_quiet_in_reset;
    @(posedge CLK) !ARESETN |=> !m_axis_tvalid;
  endproperty

  property p_hold_when_stalled;
    @(posedge CLK) disable iff (!ARESETN)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata);
  endproperty

  property p_low_bits_zero;  // samples are left-aligned in the word.
    @(posedge CLK) disable iff (!ARESETN)
      m_axis_tvalid |-> m_axis_tdata[PAD_WIDTH-1:0] == '0;
  endproperty

  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else $error("m_axis_tvalid is high after a reset edge");

  a_hold_when_stalled: assert property (p_hold_when_stalled)
    else $error("m_axis_tvalid or m_axis_tdata changed during a stall");

  a_low_bits_zero: assert property (p_low_bits_zero)
    else $error("m_axis_tdata has nonzero low bits: 0x%h", m_axis_tdata);

endmodule

bind adc_stream_top adc_stream_assertions asrt0 (
  .CLK           (CLK),
  .ARESETN       (ARESETN),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready)
);

`default_nettype wire

//--- testbench/adc_stream_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "adc_stream_cfg.svh"

module adc_stream_tb;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int PAD_WIDTH      = `ADC_WORD_WIDTH - `ADC_RES_WIDTH;
  localparam int WPB            = adc_stream_pkg::WORDS_PER_BEAT;

  logic                   CLK;
  logic                   ARESETN;
  adc_stream_pkg::limit_t count_limit;
  logic                   m_axis_tready;
  adc_stream_pkg::word_t  m_axis_tdata;
  logic                   m_axis_tvalid;

  logic [31:0]             rng_state;
  adc_stream_pkg::sample_t model_sample;
  adc_stream_pkg::limit_t  model_limit;
  int                      model_word_idx;
  int                      value_errs;
  int                      timeout_errs;
  int                      words_checked;
  bit                      timed_out;

  adc_stream_top dut0 (
    .CLK           (CLK),
    .ARESETN       (ARESETN),
    .count_limit   (count_limit),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // the ramp returns to zero once the sample reaches twice the limit.
  function automatic adc_stream_pkg::sample_t next_sample(input adc_stream_pkg::sample_t v,
                                                          input adc_stream_pkg::limit_t lim);
    int v_int;
    int twice;
    v_int = int'(v);
    twice = 2 * int'(lim);
    if (v_int >= twice) begin
      return '0;
    end
    return adc_stream_pkg::sample_t'(v_int + 1);
  endfunction

  task automatic model_reset(input adc_stream_pkg::limit_t lim);
    model_limit    = lim;
    model_sample   = '0;
    model_word_idx = 0;
  endtask

  // one beat gives eight words of the same sample.
  task automatic model_advance();
    model_word_idx++;
    if (model_word_idx == WPB) begin
      model_word_idx = 0;
      model_sample   = next_sample(model_sample, model_limit);
    end
  endtask

  task automatic check_word(input string name, input adc_stream_pkg::word_t got,
                            input adc_stream_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errs++;
    end
  endtask

  task automatic check_sample(input string name, input adc_stream_pkg::sample_t got,
                              input adc_stream_pkg::sample_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errs++;
    end
  endtask

  task automatic apply_reset(input adc_stream_pkg::limit_t lim);
    @(negedge CLK);
    ARESETN       = 1'b0;
    count_limit   = lim;
    m_axis_tready = 1'b0;
    repeat (2) @(negedge CLK);
    check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
    repeat (6) @(negedge CLK);
    ARESETN = 1'b1;
    model_reset(lim);
  endtask

  // waits for one transfer and sets tready on each falling edge.
  task automatic get_word(input bit random_ready, output adc_stream_pkg::word_t w,
                          output bit ok);
    int n;
    ok = 1'b0;
    w  = '0;
    n  = 0;
    while (!ok && n < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      if (random_ready) begin
        rng_state     = xorshift32(rng_state);
        m_axis_tready = rng_state[0];
      end else begin
        m_axis_tready = 1'b1;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        w  = m_axis_tdata;  // transfers on the coming rising edge.
        ok = 1'b1;
      end
      n++;
    end
    if (!ok) begin
      $display("timeout: no word arrived on m_axis_tdata within %0d cycles at %0t",
               TIMEOUT_CYCLES, $time);
      timeout_errs++;
      timed_out = 1'b1;
    end
  endtask

  task automatic release_ready();
    @(negedge CLK);
    m_axis_tready = 1'b0;
  endtask

  task automatic pull_words(input int n, input bit random_ready);
    adc_stream_pkg::word_t w;
    adc_stream_pkg::word_t exp;
    bit                    ok;
    for (int i = 0; i < n && !timed_out; i++) begin
      get_word(random_ready, w, ok);
      if (ok) begin
        exp = adc_stream_pkg::word_t'(model_sample) << PAD_WIDTH;
        check_word("m_axis_tdata", w, exp);
        check_sample("m_axis_tdata[15:4]", w[`ADC_WORD_WIDTH-1 -: `ADC_RES_WIDTH],
                     model_sample);
        words_checked++;
        model_advance();
      end
    end
    release_ready();
  endtask

  task automatic free_running_ramp();
    apply_reset(12'hfff);  // wrap point out of reach.
    pull_words(40 * WPB, 1'b0);
  endtask

  task automatic wrap_at_limit();
    apply_reset(12'd5);
    pull_words(3 * 11 * WPB, 1'b0);  // three periods of 0 to 10.
  endtask

  task automatic random_back_pressure();
    apply_reset(12'd9);
    pull_words(25 * WPB, 1'b1);
  endtask

  task automatic reset_mid_stream();
    apply_reset(12'd3);
    pull_words(21, 1'b1);  // stops in the middle of a beat.
    apply_reset(12'd2);
    pull_words(3 * 5 * WPB, 1'b0);
  endtask

  task automatic word_format();
    apply_reset(12'd1);
    pull_words(6 * WPB, 1'b1);
  endtask

  initial begin
    ARESETN       = 1'b0;
    count_limit   = '0;
    m_axis_tready = 1'b0;
    rng_state     = 32'ha8e40352;
    value_errs    = 0;
    timeout_errs  = 0;
    words_checked = 0;
    timed_out     = 1'b0;
    model_reset('0);

    free_running_ramp();
    if (!timed_out) begin
      wrap_at_limit();
    end
    if (!timed_out) begin
      random_back_pressure();
    end
    if (!timed_out) begin
      reset_mid_stream();
    end
    if (!timed_out) begin
      word_format();
    end

    $display("errors: %0d value, %0d timeout, %0d words checked",
             value_errs, timeout_errs, words_checked);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
hw/adc_stream_pkg.sv
hw/adc_dummy_source.sv
hw/axis_fifo.sv
hw/beat_serializer.sv
hw/adc_stream_top.sv
testbench/adc_stream_assertions.sv
testbench/adc_stream_tb.sv

//--- Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := adc_stream_tb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail, the exit code of the model does not.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
